//--- logic/execPkg.sv
package execPkg;

    // Datapath widths
    localparam int WORD_W = 32;
    localparam int REG_W  = 4;
    localparam int IMM_W  = 16;

    typedef logic [WORD_W-1:0] word;
    typedef logic [REG_W-1:0]  regIdx;
    typedef logic [IMM_W-1:0]  immVal;
    typedef logic [3:0]        flagsT;   // NZCV
    typedef logic [2:0]        aluOpT;

    // Internal ALU operations
    localparam aluOpT ALU_ADD = 3'd0;
    localparam aluOpT ALU_SUB = 3'd1;
    localparam aluOpT ALU_AND = 3'd2;
    localparam aluOpT ALU_OR  = 3'd3;
    localparam aluOpT ALU_XOR = 3'd4;

    // Bit positions inside flagsT
    localparam int FLAG_N = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

    // First level decode
    localparam logic [1:0] CLASS_DATA_IMM = 2'd0;
    localparam logic [1:0] CLASS_DATA_REG = 2'd1;
    localparam logic [1:0] CLASS_MEM      = 2'd2;
    localparam logic [1:0] CLASS_BRANCH   = 2'd3;

    // Second level decode, S forms have bit 3 set
    localparam logic [3:0] OP_ADD  = 4'd1;
    localparam logic [3:0] OP_SUB  = 4'd2;
    localparam logic [3:0] OP_AND  = 4'd3;
    localparam logic [3:0] OP_ADDS = 4'd9;
    localparam logic [3:0] OP_SUBS = 4'd10;
    localparam logic [3:0] OP_ANDS = 4'd11;
    localparam logic [3:0] OP_ORS  = 4'd12;
    localparam logic [3:0] OP_XORS = 4'd13;

    localparam logic [2:0] MOVE_MOVF = 3'd6;

    localparam logic [3:0] BR_EQ = 4'd0;
    localparam logic [3:0] BR_NE = 4'd1;
    localparam logic [3:0] BR_MI = 4'd4;

    // How the flag register is updated
    localparam logic [1:0] FLAGS_KEEP = 2'd0;
    localparam logic [1:0] FLAGS_NZ   = 2'd1;
    localparam logic [1:0] FLAGS_NZCV = 2'd2;

endpackage

//--- logic/execDecode.sv
`timescale 1ns/1ps

module execDecode import execPkg::*; (
    input  logic [1:0] firstLevelDecode,
    input  logic       specialEncoding,
    input  logic [3:0] secondLevelDecode,
    input  logic [2:0] aluFunctions,
    input  regIdx      destReg,
    input  regIdx      sourceFirstReg,
    input  regIdx      sourceSecReg,
    output regIdx      readRegDest,
    output regIdx      readRegFirst,
    output regIdx      readRegSec,
    output aluOpT      aluOp,
    output logic [1:0] flagMode,
    output logic       useImm,
    output logic       writeToReg,
    output logic       isLoad,
    output logic       isStore,
    output logic       isFlagMove,
    output logic       isBranch
);

    always_comb begin
        readRegDest  = '0;
        readRegFirst = '0;
        readRegSec   = '0;
        aluOp        = ALU_ADD;
        flagMode     = FLAGS_KEEP;
        useImm       = 1'b0;
        writeToReg   = 1'b0;
        isLoad       = 1'b0;
        isStore      = 1'b0;
        isFlagMove   = 1'b0;
        isBranch     = 1'b0;

        case (firstLevelDecode)
            CLASS_DATA_IMM: begin
                if (specialEncoding) begin
                    useImm     = 1'b1;
                    writeToReg = 1'b1;   // cleared again below if code unknown
                    case (secondLevelDecode)
                        OP_ADD:  aluOp = ALU_ADD;
                        OP_SUB:  aluOp = ALU_SUB;
                        OP_AND:  aluOp = ALU_AND;
                        OP_ADDS: begin
                            aluOp    = ALU_ADD;
                            flagMode = FLAGS_NZCV;
                        end
                        OP_SUBS: begin
                            aluOp    = ALU_SUB;
                            flagMode = FLAGS_NZCV;
                        end
                        OP_ANDS: begin
                            aluOp    = ALU_AND;
                            flagMode = FLAGS_NZ;   // logical ops keep C and V
                        end
                        OP_ORS: begin
                            aluOp    = ALU_OR;
                            flagMode = FLAGS_NZ;
                        end
                        OP_XORS: begin
                            aluOp    = ALU_XOR;
                            flagMode = FLAGS_NZ;
                        end
                        default: writeToReg = 1'b0;
                    endcase
                    if (writeToReg) begin
                        readRegDest  = destReg;
                        readRegFirst = sourceFirstReg;
                    end
                end else if (aluFunctions == MOVE_MOVF) begin
                    readRegDest = destReg;   // upper bits of old dest are kept
                    writeToReg  = 1'b1;
                    isFlagMove  = 1'b1;
                end
            end

            CLASS_DATA_REG: begin
                // Only add and subtract exist in the register form
                writeToReg = 1'b1;
                case (secondLevelDecode)
                    OP_ADD:  aluOp = ALU_ADD;
                    OP_SUB:  aluOp = ALU_SUB;
                    OP_ADDS: begin
                        aluOp    = ALU_ADD;
                        flagMode = FLAGS_NZCV;
                    end
                    OP_SUBS: begin
                        aluOp    = ALU_SUB;
                        flagMode = FLAGS_NZCV;
                    end
                    default: writeToReg = 1'b0;
                endcase
                if (writeToReg) begin
                    readRegDest  = destReg;
                    readRegFirst = sourceFirstReg;
                    readRegSec   = sourceSecReg;
                end
            end

            CLASS_MEM: begin
                readRegFirst = sourceFirstReg;   // Base
                readRegDest  = destReg;          // Store data or load target
                if (aluFunctions[0]) begin
                    isStore = 1'b1;
                end else begin
                    isLoad     = 1'b1;
                    writeToReg = 1'b1;
                end
            end

            CLASS_BRANCH: isBranch = 1'b1;
        endcase
    end

endmodule

//--- logic/execAlu.sv
`timescale 1ns/1ps

module execAlu import execPkg::*; (
    input  word   opA,
    input  word   opB,
    input  aluOpT aluOp,
    output word   aluResult,
    output flagsT aluFlags
);

    logic [WORD_W:0] sum;    // Extra bit is the carry out
    logic [WORD_W:0] diff;   // Extra bit is the borrow
    word             result;
    logic            carry;
    logic            overflow;

    assign sum  = {1'b0, opA} + {1'b0, opB};
    assign diff = {1'b0, opA} - {1'b0, opB};

    always_comb begin
        result   = '0;
        carry    = 1'b0;
        overflow = 1'b0;

        case (aluOp)
            ALU_ADD: begin
                result   = sum[WORD_W-1:0];
                carry    = sum[WORD_W];
                // Same sign in, other sign out
                overflow = (opA[WORD_W-1] == opB[WORD_W-1]) &&
                           (result[WORD_W-1] != opA[WORD_W-1]);
            end

            ALU_SUB: begin
                result   = diff[WORD_W-1:0];
                carry    = ~diff[WORD_W];   // C is NOT borrow
                overflow = (opA[WORD_W-1] != opB[WORD_W-1]) &&
                           (result[WORD_W-1] != opA[WORD_W-1]);
            end

            ALU_AND: result = opA & opB;
            ALU_OR:  result = opA | opB;
            ALU_XOR: result = opA ^ opB;

            default: result = '0;
        endcase
    end

    assign aluResult = result;

    // C and V stay 0 for logical ops, the flag register ignores them there
    always_comb begin
        aluFlags         = '0;
        aluFlags[FLAG_N] = result[WORD_W-1];
        aluFlags[FLAG_Z] = (result == '0);
        aluFlags[FLAG_C] = carry;
        aluFlags[FLAG_V] = overflow;
    end

endmodule

//--- logic/flagBranch.sv
`timescale 1ns/1ps

module flagBranch import execPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  flagsT      aluFlags,
    input  logic [1:0] flagMode,
    input  logic       isBranch,
    input  logic [3:0] branchInstruction,
    output flagsT      flags,
    output logic       exeOverride
);

    // NZCV register, visible to the branch test one cycle later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags <= '0;
        end else begin
            case (flagMode)
                FLAGS_NZCV: flags <= aluFlags;
                FLAGS_NZ: begin
                    flags[FLAG_N] <= aluFlags[FLAG_N];
                    flags[FLAG_Z] <= aluFlags[FLAG_Z];
                end
                default: flags <= flags;   // Keep
            endcase
        end
    end

    // Branch condition against the registered flags only
    always_comb begin
        exeOverride = 1'b0;
        if (isBranch) begin
            case (branchInstruction)
                BR_EQ:   exeOverride = flags[FLAG_Z];
                BR_NE:   exeOverride = ~flags[FLAG_Z];
                BR_MI:   exeOverride = flags[FLAG_N];
                default: exeOverride = 1'b0;
            endcase
        end
    end

endmodule

//--- logic/execute.sv
`timescale 1ns/1ps

module execute import execPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] firstLevelDecode,
    input  logic       specialEncoding,
    input  logic [3:0] secondLevelDecode,
    input  logic [2:0] aluFunctions,
    input  logic [3:0] branchInstruction,
    input  immVal      imm,
    input  regIdx      destReg,
    input  regIdx      sourceFirstReg,
    input  regIdx      sourceSecReg,
    input  word        readDataDest,
    input  word        readDataFirst,
    input  word        readDataSec,
    input  word        memoryDataIn,
    output regIdx      readRegDest,
    output regIdx      readRegFirst,
    output regIdx      readRegSec,
    output word        writeData,
    output logic       writeToReg,
    output logic       exeOverride,
    output word        memoryDataOut,
    output word        memoryAddressOut,
    output logic       memoryWrite,
    output logic       memoryRead
);

    aluOpT      aluOp;
    logic [1:0] flagMode;
    logic       useImm;
    logic       isLoad;
    logic       isStore;
    logic       isFlagMove;
    logic       isBranch;
    word        immExt;
    word        opB;
    word        aluResult;
    flagsT      aluFlags;
    flagsT      flags;

    execDecode decode (
        .firstLevelDecode (firstLevelDecode),
        .specialEncoding  (specialEncoding),
        .secondLevelDecode(secondLevelDecode),
        .aluFunctions     (aluFunctions),
        .destReg          (destReg),
        .sourceFirstReg   (sourceFirstReg),
        .sourceSecReg     (sourceSecReg),
        .readRegDest      (readRegDest),
        .readRegFirst     (readRegFirst),
        .readRegSec       (readRegSec),
        .aluOp            (aluOp),
        .flagMode         (flagMode),
        .useImm           (useImm),
        .writeToReg       (writeToReg),
        .isLoad           (isLoad),
        .isStore          (isStore),
        .isFlagMove       (isFlagMove),
        .isBranch         (isBranch)
    );

    assign immExt = {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};   // Sign extend
    assign opB    = useImm ? immExt : readDataSec;

    execAlu alu (
        .opA      (readDataFirst),
        .opB      (opB),
        .aluOp    (aluOp),
        .aluResult(aluResult),
        .aluFlags (aluFlags)
    );

    flagBranch flagUnit (
        .clk              (clk),
        .rst              (rst),
        .aluFlags         (aluFlags),
        .flagMode         (flagMode),
        .isBranch         (isBranch),
        .branchInstruction(branchInstruction),
        .flags            (flags),
        .exeOverride      (exeOverride)
    );

    // Memory side
    assign memoryWrite      = isStore;
    assign memoryRead       = isLoad;
    assign memoryAddressOut = (isLoad || isStore) ? readDataFirst + immExt : '0;
    assign memoryDataOut    = isStore ? readDataDest : '0;

    // Write-back select, writeToReg alone marks an ALU op here
    always_comb begin
        if (isLoad)
            writeData = memoryDataIn;
        else if (isFlagMove)
            writeData = {23'd0, readDataDest[31:27], flags};   // MOVF layout
        else if (writeToReg)
            writeData = aluResult;
        else
            writeData = '0;
    end

endmodule

//--- tb/execute_chk.sv
`timescale 1ns/1ps

module executeChk import execPkg::*; (
    input logic       clk,
    input logic       rst,
    input logic [1:0] firstLevelDecode,
    input logic       writeToReg,
    input logic       exeOverride,
    input logic       memoryWrite,
    input logic       memoryRead,
    input flagsT      flags
);

    memExclusive: assert property (@(posedge clk) disable iff (rst)
        !(memoryWrite && memoryRead))
        else $error("memoryWrite and memoryRead are high together");

    storeNoWrite: assert property (@(posedge clk) disable iff (rst)
        memoryWrite |-> !writeToReg)
        else $error("writeToReg is high during a store");

    // Only branches may redirect the fetch
    overrideBranch: assert property (@(posedge clk) disable iff (rst)
        (firstLevelDecode != CLASS_BRANCH) |-> !exeOverride)
        else $error("exeOverride is high outside the branch class");

    flagsCleared: assert property (@(posedge clk) $fell(rst) |-> (flags == '0))
        else $error("flags are not 0000 after reset");

endmodule

bind execute executeChk chk (
    .clk             (clk),
    .rst             (rst),
    .firstLevelDecode(firstLevelDecode),
    .writeToReg      (writeToReg),
    .exeOverride     (exeOverride),
    .memoryWrite     (memoryWrite),
    .memoryRead      (memoryRead),
    .flags           (flags)
);

//--- tb/execTb.sv
`timescale 1ns/1ps

module execTb import execPkg::*; ();

    logic       clk = 1'b0;
    logic       rst;
    logic [1:0] firstLevelDecode;
    logic       specialEncoding;
    logic [3:0] secondLevelDecode;
    logic [2:0] aluFunctions;
    logic [3:0] branchInstruction;
    immVal      imm;
    regIdx      destReg;
    regIdx      sourceFirstReg;
    regIdx      sourceSecReg;
    word        readDataDest;
    word        readDataFirst;
    word        readDataSec;
    word        memoryDataIn;
    regIdx      readRegDest;
    regIdx      readRegFirst;
    regIdx      readRegSec;
    word        writeData;
    word        memoryDataOut;
    word        memoryAddressOut;
    logic       writeToReg;
    logic       exeOverride;
    logic       memoryWrite;
    logic       memoryRead;

    string vecLines[$];   // Raw test lines, comments removed
    int    vecCount;
    bit    counted = 1'b0;

    execute UUT (.*);

    always #5 clk = ~clk;

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "Run stopped");
    endtask

    task automatic checkWord(input string name, input string field, input word expected,
                             input word actual);
        if (actual !== expected)
            stopRun($sformatf("ERR %s %s expected %h actual %h", name, field, expected, actual));
    endtask

    task automatic checkRegIdx(input string name, input string field, input regIdx expected,
                               input regIdx actual);
        if (actual !== expected)
            stopRun($sformatf("ERR %s %s expected %h actual %h", name, field, expected, actual));
    endtask

    task automatic checkBit(input string name, input string field, input logic expected,
                            input logic actual);
        if (actual !== expected)
            stopRun($sformatf("ERR %s %s expected %b actual %b", name, field, expected, actual));
    endtask

    task automatic loadVectors();
        int    fd;
        string line;
        fd = $fopen("tb/execVectors.txt", "r");
        if (fd == 0) begin
            stopRun("Cannot open the vector file tb/execVectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#")   // Skip blanks and column notes
                    vecLines.push_back(line);
            end
            $fclose(fd);
        end
    endtask

    task automatic runVector(input string line);
        string      name;
        logic [1:0] cls;
        logic [3:0] op, br;
        logic [2:0] fn, dcMask;
        logic       spc, eWr, eMw, eMr, eOvr;
        immVal      im;
        regIdx      dst, fst, sec, eRd, eRf, eRs;
        word        dD, dF, dS, mIn, eWd, eAddr, eMdat;
        int         nFields;
        nFields = $sscanf(line,
            "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            name, cls, spc, op, fn, br, im, dst, fst, sec, dcMask, dD, dF, dS, mIn,
            eWr, eWd, eRd, eRf, eRs, eMw, eMr, eAddr, eMdat, eOvr);
        if (nFields != 25) begin
            stopRun($sformatf("Vector line has %0d fields instead of 25: %s", nFields, line));
        end else begin
            if (dcMask[2]) dD = $urandom();   // Data the operation must ignore
            if (dcMask[1]) dF = $urandom();
            if (dcMask[0]) dS = $urandom();
            @(posedge clk);
            firstLevelDecode  <= cls;
            specialEncoding   <= spc;
            secondLevelDecode <= op;
            aluFunctions      <= fn;
            branchInstruction <= br;
            imm               <= im;
            destReg           <= dst;
            sourceFirstReg    <= fst;
            sourceSecReg      <= sec;
            readDataDest      <= dD;
            readDataFirst     <= dF;
            readDataSec       <= dS;
            memoryDataIn      <= mIn;
            @(negedge clk);   // Outputs settled, flags stable until next edge
            checkBit(name, "writeToReg", eWr, writeToReg);
            checkWord(name, "writeData", eWd, writeData);
            checkRegIdx(name, "readRegDest", eRd, readRegDest);
            checkRegIdx(name, "readRegFirst", eRf, readRegFirst);
            checkRegIdx(name, "readRegSec", eRs, readRegSec);
            checkBit(name, "memoryWrite", eMw, memoryWrite);
            checkBit(name, "memoryRead", eMr, memoryRead);
            checkWord(name, "memoryAddressOut", eAddr, memoryAddressOut);
            checkWord(name, "memoryDataOut", eMdat, memoryDataOut);
            checkBit(name, "exeOverride", eOvr, exeOverride);
        end
    endtask

    initial begin
        rst               = 1'b1;
        firstLevelDecode  = '0;
        specialEncoding   = 1'b0;
        secondLevelDecode = '0;
        aluFunctions      = '0;
        branchInstruction = '0;
        imm               = '0;
        destReg           = '0;
        sourceFirstReg    = '0;
        sourceSecReg      = '0;
        readDataDest      = '0;
        readDataFirst     = '0;
        readDataSec       = '0;
        memoryDataIn      = '0;
        void'($urandom(32'h5138));
        loadVectors();
        vecCount = vecLines.size();
        counted  = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        foreach (vecLines[i])
            runVector(vecLines[i]);
        if (vecCount == 0) begin
            stopRun("The vector file holds no tests");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

    // Watchdog, reset and margin fit in the extra 20 cycles
    initial begin
        wait (counted);
        #((vecCount + 20) * 10);
        stopRun("Timeout, the vector run did not finish in time");
    end

endmodule

//--- tb/execVectors.txt
# name cls spc op fn br imm dst src1 src2 dcMask(dest,first,sec random) dataDest dataFirst dataSec memIn
# expected: writeToReg writeData rdDest rdFirst rdSec memWrite memRead address storeData override
rstBne 3 0 0 0 1 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 1
rstBeq 3 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0
rstBmi 3 0 0 0 4 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0
unkBr 3 0 0 0 7 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0
unkImm 0 1 5 0 0 1234 3 4 5 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0
unkReg 1 0 3 0 0 0 2 3 4 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0
unkMove 0 0 0 2 0 0 5 6 7 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0
movfRst 0 0 0 6 0 0 5 0 0 3 F8000000 0 0 0 1 1F0 5 0 0 0 0 0 0 0
addReg 1 0 1 0 0 0 1 2 3 4 0 FFFFFFFF 2 0 1 1 1 2 3 0 0 0 0 0
subReg 1 0 2 0 0 0 4 5 6 4 0 5 5 0 1 0 4 5 6 0 0 0 0 0
bneKeep 3 0 0 0 1 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 1
addsReg 1 0 9 0 0 0 1 2 3 4 0 7FFFFFFF 1 0 1 80000000 1 2 3 0 0 0 0 0
bmiN 3 0 0 0 4 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 1
movfNV 0 0 0 6 0 0 7 0 0 3 0 0 0 0 1 9 7 0 0 0 0 0 0 0
subsImm 0 1 A 0 0 5 2 3 0 5 0 5 0 0 1 0 2 3 0 0 0 0 0 0
beqZ 3 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 1
bneZ 3 0 0 0 1 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0
movfZC 0 0 0 6 0 0 8 0 0 3 08000000 0 0 0 1 16 8 0 0 0 0 0 0 0
addsImm 0 1 9 0 0 8000 3 4 0 5 0 80000000 0 0 1 7FFF8000 3 4 0 0 0 0 0 0
movfCV 0 0 0 6 0 0 9 0 0 3 0 0 0 0 1 3 9 0 0 0 0 0 0 0
subsReg 1 0 A 0 0 0 1 2 3 4 0 3 5 0 1 FFFFFFFE 1 2 3 0 0 0 0 0
bmiNeg 3 0 0 0 4 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 1
beqNeg 3 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0
addsCV 1 0 9 0 0 0 5 6 7 4 0 80000000 80000000 0 1 0 5 6 7 0 0 0 0 0
andsImm 0 1 B 0 0 F0 6 7 0 5 0 F0F0F0F0 0 0 1 F0 6 7 0 0 0 0 0 0
movfAnd 0 0 0 6 0 0 A 0 0 3 0 0 0 0 1 3 A 0 0 0 0 0 0 0
orsImm 0 1 C 0 0 8000 6 7 0 5 0 1 0 0 1 FFFF8001 6 7 0 0 0 0 0 0
bmiOr 3 0 0 0 4 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 1
xorsImm 0 1 D 0 0 FFFF 6 7 0 5 0 FFFFFFFF 0 0 1 0 6 7 0 0 0 0 0 0
movfXor 0 0 0 6 0 0 B 0 0 3 0 0 0 0 1 7 B 0 0 0 0 0 0 0
addImm 0 1 1 0 0 FFFF 1 2 0 5 0 10 0 0 1 F 1 2 0 0 0 0 0 0
andImm 0 1 3 0 0 0FF0 1 2 0 5 0 12345678 0 0 1 670 1 2 0 0 0 0 0 0
subImm 0 1 2 0 0 10 1 2 0 5 0 0 0 0 1 FFFFFFF0 1 2 0 0 0 0 0 0
beqKeep 3 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 1
storeW 2 0 0 1 0 FFFC 3 4 0 1 CAFEF00D 1000 0 11111111 0 0 3 4 0 1 0 FFC CAFEF00D 0
loadW 2 0 0 0 0 10 5 6 0 5 0 2000 0 DEADBEEF 1 DEADBEEF 5 6 0 0 1 2010 0 0

//--- compile.f
logic/execPkg.sv
logic/execDecode.sv
logic/execAlu.sv
logic/flagBranch.sv
logic/execute.sv
tb/execute_chk.sv
tb/execTb.sv

//--- Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= execTb
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --assert -j 0

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the pass or fail result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
